// File: common/spmm_pkg.sv
package spmm_pkg;

  // Element and matrix sizes
  localparam int DATA_WIDTH      = 8;
  localparam int NUM_FEATURE_IN  = 64;
  localparam int NUM_FEATURE_OUT = 4;
  localparam int MAX_NODES       = 16;
  localparam int ACC_WIDTH       = 20;

  // Derived index widths
  localparam int COL_IDX_WIDTH   = $clog2(NUM_FEATURE_IN);
  // Row length must hold 0 up to NUM_FEATURE_IN inclusive
  localparam int ROW_LEN_WIDTH   = $clog2(NUM_FEATURE_IN + 1);
  localparam int NUM_NODE_WIDTH  = $clog2(MAX_NODES);

  // Scalar types
  typedef logic signed [DATA_WIDTH-1:0]     data_t;
  typedef logic        [COL_IDX_WIDTH-1:0]  col_idx_t;
  typedef logic        [ROW_LEN_WIDTH-1:0]  row_len_t;
  typedef logic        [NUM_NODE_WIDTH-1:0] node_cnt_t;
  typedef logic signed [ACC_WIDTH-1:0]      acc_t;

  // One row of W, lane 0 in the low bits
  typedef data_t [NUM_FEATURE_OUT-1:0] wgt_row_t;

  // One row of WH, one signed sum per output lane
  typedef acc_t [NUM_FEATURE_OUT-1:0] res_vec_t;

  // CSR reader states
  typedef enum logic [1:0] {
    RD_IDLE   = 2'd0,
    RD_STREAM = 2'd1,
    RD_EMPTY  = 2'd2
  } reader_state_e;

endpackage

// File: common/nz_stream_if.sv
`timescale 1ns/1ns

interface nz_stream_if;
  import spmm_pkg::*;

  logic      valid;
  logic      ready;
  col_idx_t  col_idx;
  data_t     val;
  // Row markers, set by the reader
  logic      first;
  logic      last;
  logic      empty_row;
  // Per-row node info carried with every entry
  node_cnt_t num_node;
  logic      src_flag;

  modport src (
    output valid, col_idx, val, first, last, empty_row, num_node, src_flag,
    input  ready
  );

  modport dst (
    input  valid, col_idx, val, first, last, empty_row, num_node, src_flag,
    output ready
  );

endinterface

// File: design/csr_row_reader.sv
`timescale 1ns/1ns

module csr_row_reader (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               hdr_valid_i,
  input  spmm_pkg::row_len_t  hdr_row_len_i,
  input  spmm_pkg::node_cnt_t hdr_num_node_i,
  input  logic               hdr_src_flag_i,
  output logic               hdr_ready_o,
  input  logic               nz_valid_i,
  input  spmm_pkg::col_idx_t  nz_col_idx_i,
  input  spmm_pkg::data_t     nz_val_i,
  output logic               nz_ready_o,
  nz_stream_if.src           nz_o
);
  import spmm_pkg::*;

  reader_state_e state_q;
  reader_state_e state_d;
  row_len_t      remain_q;
  logic          first_q;
  node_cnt_t     num_node_q;
  logic          src_flag_q;
  logic          hdr_rdy_q;
  logic          hdr_fire;
  logic          nz_fire;
  logic          streaming;

  assign streaming = (state_q == RD_STREAM);
  assign hdr_fire  = hdr_valid_i && hdr_ready_o;
  assign nz_fire   = streaming && nz_valid_i && nz_o.ready;

  // Header side is registered so it stays low through reset
  assign hdr_ready_o = hdr_rdy_q;
  assign nz_ready_o  = streaming && nz_o.ready;

  always_comb begin
    state_d = state_q;
    case (state_q)
      RD_IDLE: begin
        if (hdr_fire) begin
          state_d = (hdr_row_len_i == '0) ? RD_EMPTY : RD_STREAM;
        end
      end
      RD_STREAM: begin
        if (nz_fire && remain_q == row_len_t'(1)) begin
          state_d = RD_IDLE;
        end
      end
      RD_EMPTY: begin
        if (nz_o.ready) begin
          state_d = RD_IDLE;
        end
      end
      default: state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= RD_IDLE;
      hdr_rdy_q  <= 1'b0;
      remain_q   <= '0;
      first_q    <= 1'b0;
      num_node_q <= '0;
      src_flag_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      hdr_rdy_q <= (state_d == RD_IDLE);
      if (hdr_fire) begin
        remain_q   <= hdr_row_len_i;
        first_q    <= 1'b1;
        num_node_q <= hdr_num_node_i;
        src_flag_q <= hdr_src_flag_i;
      end else if (nz_fire) begin
        remain_q <= remain_q - row_len_t'(1);
        first_q  <= 1'b0;
      end
    end
  end

  // Nonzeros pass straight through, an empty row gets one synthetic entry
  assign nz_o.valid     = streaming ? nz_valid_i : (state_q == RD_EMPTY);
  assign nz_o.col_idx   = streaming ? nz_col_idx_i : '0;
  assign nz_o.val       = streaming ? nz_val_i : '0;
  assign nz_o.first     = streaming ? first_q : 1'b1;
  assign nz_o.last      = streaming ? (remain_q == row_len_t'(1)) : 1'b1;
  assign nz_o.empty_row = !streaming;
  assign nz_o.num_node  = num_node_q;
  assign nz_o.src_flag  = src_flag_q;

endmodule

// File: design/nz_fifo.sv
`timescale 1ns/1ns

module nz_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic     clk,
  input  logic     rst_n,
  nz_stream_if.dst in_i,
  nz_stream_if.src out_o
);
  import spmm_pkg::*;

  localparam int AW      = $clog2(FIFO_DEPTH);
  localparam int ENTRY_W = COL_IDX_WIDTH + DATA_WIDTH + 3 + NUM_NODE_WIDTH + 1;

  logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
  logic [AW:0]        wr_ptr;
  logic [AW:0]        rd_ptr;
  logic               full;
  logic               empty;
  logic               push;
  logic               pop;

  // Extra top bit tells full from empty when the indices match
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  assign in_i.ready  = !full;
  assign out_o.valid = !empty;

  assign push = in_i.valid && in_i.ready;
  assign pop  = out_o.valid && out_o.ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[AW-1:0]] <= {in_i.col_idx, in_i.val, in_i.first, in_i.last,
                              in_i.empty_row, in_i.num_node, in_i.src_flag};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Head entry read without a register
  assign {out_o.col_idx, out_o.val, out_o.first, out_o.last,
          out_o.empty_row, out_o.num_node, out_o.src_flag} = mem[rd_ptr[AW-1:0]];

endmodule

// File: sparse_pe/weight_bank.sv
`timescale 1ns/1ns

module weight_bank (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               we_i,
  input  spmm_pkg::col_idx_t waddr_i,
  input  spmm_pkg::wgt_row_t wdata_i,
  input  logic               rd_en_i,
  input  spmm_pkg::col_idx_t raddr_i,
  output spmm_pkg::wgt_row_t rdata_o
);
  import spmm_pkg::*;

  // One entry per row of W
  wgt_row_t mem [NUM_FEATURE_IN];
  wgt_row_t rdata_q;

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Read register holds its row while the PE is stalled
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (rd_en_i) begin
      rdata_q <= mem[raddr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: sparse_pe/sparse_pe.sv
`timescale 1ns/1ns

module sparse_pe (
  input  logic                clk,
  input  logic                rst_n,
  nz_stream_if.dst            nz_i,
  output logic                wgt_rd_en_o,
  output spmm_pkg::col_idx_t  wgt_addr_o,
  input  spmm_pkg::wgt_row_t  wgt_row_i,
  output logic                res_valid_o,
  output spmm_pkg::res_vec_t  res_o,
  output spmm_pkg::node_cnt_t res_num_node_o,
  output logic                res_src_flag_o,
  input  logic                res_ready_i
);
  import spmm_pkg::*;

  logic      adv;
  logic      pop;

  // Stage 1, entry waiting for its weight row
  logic      s1_valid;
  data_t     s1_val;
  logic      s1_first;
  logic      s1_last;
  logic      s1_empty;
  node_cnt_t s1_num_node;
  logic      s1_src_flag;

  // Stage 2, lane sums of the current row
  res_vec_t  acc_q;
  logic      s2_done;
  node_cnt_t s2_num_node;
  logic      s2_src_flag;
  acc_t      prod [NUM_FEATURE_OUT];

  // Result register
  logic      res_valid_q;
  res_vec_t  res_q;
  node_cnt_t res_num_node_q;
  logic      res_src_flag_q;

  // Whole pipe moves only when the result slot is free or draining
  assign adv = !res_valid_q || res_ready_i;
  assign pop = nz_i.valid && adv;

  assign nz_i.ready  = adv;
  assign wgt_rd_en_o = adv;
  assign wgt_addr_o  = nz_i.col_idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (adv) begin
      s1_valid <= nz_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      s1_val      <= nz_i.val;
      s1_first    <= nz_i.first;
      s1_last     <= nz_i.last;
      s1_empty    <= nz_i.empty_row;
      s1_num_node <= nz_i.num_node;
      s1_src_flag <= nz_i.src_flag;
    end
  end

  // Products sign extended to the lane width before the multiply
  always_comb begin
    for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
      prod[l] = acc_t'($signed(s1_val)) * acc_t'($signed(wgt_row_i[l]));
    end
  end

  always_ff @(posedge clk) begin
    if (adv && s1_valid) begin
      for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
        if (s1_empty) begin
          acc_q[l] <= '0;
        end else if (s1_first) begin
          acc_q[l] <= prod[l];
        end else begin
          acc_q[l] <= acc_q[l] + prod[l];
        end
      end
      s2_num_node <= s1_num_node;
      s2_src_flag <= s1_src_flag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_done     <= 1'b0;
      res_valid_q <= 1'b0;
    end else if (adv) begin
      s2_done     <= s1_valid && s1_last;
      res_valid_q <= s2_done;
    end
  end

  always_ff @(posedge clk) begin
    if (adv && s2_done) begin
      res_q          <= acc_q;
      res_num_node_q <= s2_num_node;
      res_src_flag_q <= s2_src_flag;
    end
  end

  assign res_valid_o    = res_valid_q;
  assign res_o          = res_q;
  assign res_num_node_o = res_num_node_q;
  assign res_src_flag_o = res_src_flag_q;

endmodule

// File: design/spmm_top.sv
`timescale 1ns/1ns

module spmm_top #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                clk,
  input  logic                rst_n,
  // Row header stream
  input  logic                hdr_valid_i,
  input  spmm_pkg::row_len_t  hdr_row_len_i,
  input  spmm_pkg::node_cnt_t hdr_num_node_i,
  input  logic                hdr_src_flag_i,
  output logic                hdr_ready_o,
  // Nonzero stream
  input  logic                nz_valid_i,
  input  spmm_pkg::col_idx_t  nz_col_idx_i,
  input  spmm_pkg::data_t     nz_val_i,
  output logic                nz_ready_o,
  // Weight load port
  input  logic                wgt_we_i,
  input  spmm_pkg::col_idx_t  wgt_addr_i,
  input  spmm_pkg::wgt_row_t  wgt_data_i,
  // Result stream
  output logic                res_valid_o,
  output spmm_pkg::res_vec_t  res_o,
  output spmm_pkg::node_cnt_t res_num_node_o,
  output logic                res_src_flag_o,
  input  logic                res_ready_i
);
  import spmm_pkg::*;

  logic     wgt_rd_en;
  col_idx_t wgt_raddr;
  wgt_row_t wgt_rdata;

  nz_stream_if rd_to_fifo ();
  nz_stream_if fifo_to_pe ();

  csr_row_reader csr_row_reader_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .hdr_valid_i    (hdr_valid_i),
    .hdr_row_len_i  (hdr_row_len_i),
    .hdr_num_node_i (hdr_num_node_i),
    .hdr_src_flag_i (hdr_src_flag_i),
    .hdr_ready_o    (hdr_ready_o),
    .nz_valid_i     (nz_valid_i),
    .nz_col_idx_i   (nz_col_idx_i),
    .nz_val_i       (nz_val_i),
    .nz_ready_o     (nz_ready_o),
    .nz_o           (rd_to_fifo)
  );

  nz_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) nz_fifo_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .in_i  (rd_to_fifo),
    .out_o (fifo_to_pe)
  );

  weight_bank weight_bank_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (wgt_we_i),
    .waddr_i (wgt_addr_i),
    .wdata_i (wgt_data_i),
    .rd_en_i (wgt_rd_en),
    .raddr_i (wgt_raddr),
    .rdata_o (wgt_rdata)
  );

  sparse_pe sparse_pe_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .nz_i           (fifo_to_pe),
    .wgt_rd_en_o    (wgt_rd_en),
    .wgt_addr_o     (wgt_raddr),
    .wgt_row_i      (wgt_rdata),
    .res_valid_o    (res_valid_o),
    .res_o          (res_o),
    .res_num_node_o (res_num_node_o),
    .res_src_flag_o (res_src_flag_o),
    .res_ready_i    (res_ready_i)
  );

endmodule

// File: dv/spmm_properties.sv
`timescale 1ns/1ns

module spmm_properties (
  input logic                clk,
  input logic                rst_n,
  input logic                hdr_valid_i,
  input logic                hdr_ready_o,
  input logic                nz_ready_o,
  input logic                res_valid_o,
  input spmm_pkg::res_vec_t  res_o,
  input spmm_pkg::node_cnt_t res_num_node_o,
  input logic                res_ready_i
);

  // Result holds until the consumer takes it
  res_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    (res_valid_o && !res_ready_i) |=>
      (res_valid_o && $stable(res_o) && $stable(res_num_node_o)))
    else $error("result changed while stalled");

  // No new header while nonzeros of a row are accepted
  hdr_block_a: assert property (@(posedge clk) disable iff (!rst_n)
    nz_ready_o |-> !hdr_ready_o)
    else $error("header ready during streaming");

  // Accepted header closes the header port
  hdr_close_a: assert property (@(posedge clk) disable iff (!rst_n)
    (hdr_valid_i && hdr_ready_o) |=> !hdr_ready_o)
    else $error("header ready right after a header");

  reset_quiet_a: assert property (@(posedge clk)
    !rst_n |-> (!hdr_ready_o && !nz_ready_o && !res_valid_o))
    else $error("handshake output high in reset");

endmodule

bind spmm_top spmm_properties spmm_properties_inst (
  .clk            (clk),
  .rst_n          (rst_n),
  .hdr_valid_i    (hdr_valid_i),
  .hdr_ready_o    (hdr_ready_o),
  .nz_ready_o     (nz_ready_o),
  .res_valid_o    (res_valid_o),
  .res_o          (res_o),
  .res_num_node_o (res_num_node_o),
  .res_ready_i    (res_ready_i)
);

// File: dv/spmm_tb.sv
`timescale 1ns/1ns

module spmm_tb;
  import spmm_pkg::*;

  localparam bit [31:0] SEED       = 32'hdd83_4391;
  localparam int        N_SINGLE   = 8;
  localparam int        N_RANDOM   = 200;
  localparam int        N_BACKPR   = 60;
  localparam int        N_WRAP     = 12;
  localparam int        TOTAL_ROWS = N_SINGLE + N_RANDOM + N_RANDOM / 10 + N_BACKPR + N_WRAP;
  localparam longint    TIMEOUT_NS = 4 * TOTAL_ROWS * (NUM_FEATURE_IN + 20) * 10;

  logic      clk;
  logic      rst_n;
  logic      hdr_valid_i;
  row_len_t  hdr_row_len_i;
  node_cnt_t hdr_num_node_i;
  logic      hdr_src_flag_i;
  logic      hdr_ready_o;
  logic      nz_valid_i;
  col_idx_t  nz_col_idx_i;
  data_t     nz_val_i;
  logic      nz_ready_o;
  logic      wgt_we_i;
  col_idx_t  wgt_addr_i;
  wgt_row_t  wgt_data_i;
  logic      res_valid_o;
  res_vec_t  res_o;
  node_cnt_t res_num_node_o;
  logic      res_src_flag_o;
  logic      res_ready_i;

  // Reference state
  wgt_row_t  wgt_model [NUM_FEATURE_IN];
  res_vec_t  exp_res_q [$];
  node_cnt_t exp_node_q [$];
  bit        exp_flag_q [$];
  bit        bp_en;
  bit        gap_en;

  spmm_top spmm_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .hdr_valid_i    (hdr_valid_i),
    .hdr_row_len_i  (hdr_row_len_i),
    .hdr_num_node_i (hdr_num_node_i),
    .hdr_src_flag_i (hdr_src_flag_i),
    .hdr_ready_o    (hdr_ready_o),
    .nz_valid_i     (nz_valid_i),
    .nz_col_idx_i   (nz_col_idx_i),
    .nz_val_i       (nz_val_i),
    .nz_ready_o     (nz_ready_o),
    .wgt_we_i       (wgt_we_i),
    .wgt_addr_i     (wgt_addr_i),
    .wgt_data_i     (wgt_data_i),
    .res_valid_o    (res_valid_o),
    .res_o          (res_o),
    .res_num_node_o (res_num_node_o),
    .res_src_flag_o (res_src_flag_o),
    .res_ready_i    (res_ready_i)
  );

  always #5 clk = ~clk;

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_res(input string name, input res_vec_t got, input res_vec_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_node(input string name, input node_cnt_t got, input node_cnt_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      stop_on_error($sformatf("[FAIL] %0t %s got %0b expected %0b", $time, name, got, exp));
    end
  endtask

  // Random idle cycles before a transfer when gaps are on
  task automatic insert_gap();
    int n;
    n = gap_en ? int'($urandom_range(0, 3)) : 0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic load_weights(input bit extreme);
    wgt_row_t row;
    for (int a = 0; a < NUM_FEATURE_IN; a++) begin
      if (extreme) begin
        row[0] = data_t'(8'h80);
        row[1] = data_t'(8'h80);
        row[2] = data_t'(8'h7f);
        // Lane 3 runs from -128 to -65 over the address range
        row[3] = data_t'(8'h80 | 8'(a));
      end else begin
        row = wgt_row_t'($urandom);
      end
      wgt_model[a] = row;
      wgt_we_i     = 1'b1;
      wgt_addr_i   = col_idx_t'(a);
      wgt_data_i   = row;
      @(posedge clk);
      #1;
    end
    wgt_we_i = 1'b0;
  endtask

  task automatic send_row(input int len, input bit extreme);
    col_idx_t  cols [NUM_FEATURE_IN];
    data_t     vals [NUM_FEATURE_IN];
    int        sums [NUM_FEATURE_OUT];
    res_vec_t  exp_vec;
    node_cnt_t node;
    bit        flag;
    node = node_cnt_t'($urandom);
    flag = bit'($urandom_range(0, 1));
    for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
      sums[l] = 0;
    end
    for (int k = 0; k < len; k++) begin
      cols[k] = col_idx_t'($urandom);
      vals[k] = extreme ? data_t'(8'h80) : data_t'($urandom);
      for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
        sums[l] += int'(vals[k]) * int'($signed(wgt_model[cols[k]][l]));
      end
    end
    // Keep the low ACC_WIDTH bits of each lane
    for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
      exp_vec[l] = acc_t'(sums[l]);
    end
    exp_res_q.push_back(exp_vec);
    exp_node_q.push_back(node);
    exp_flag_q.push_back(flag);

    insert_gap();
    hdr_valid_i    = 1'b1;
    hdr_row_len_i  = row_len_t'(len);
    hdr_num_node_i = node;
    hdr_src_flag_i = flag;
    @(negedge clk);
    while (!hdr_ready_o) @(negedge clk);
    @(posedge clk);
    #1;
    hdr_valid_i = 1'b0;

    for (int k = 0; k < len; k++) begin
      insert_gap();
      nz_valid_i   = 1'b1;
      nz_col_idx_i = cols[k];
      nz_val_i     = vals[k];
      @(negedge clk);
      while (!nz_ready_o) @(negedge clk);
      @(posedge clk);
      #1;
      nz_valid_i = 1'b0;
    end
  endtask

  task automatic drain();
    while (exp_res_q.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  // Consumer ready drops at random only when back-pressure is on
  always @(posedge clk) begin
    #1;
    res_ready_i = bp_en ? ($urandom_range(0, 3) != 0) : 1'b1;
  end

  // Result sampled at the falling edge before its transfer edge
  always @(negedge clk) begin
    if (rst_n && res_valid_o && res_ready_i) begin
      if (exp_res_q.size() == 0) begin
        stop_on_error("A result arrived with no row outstanding");
      end else begin
        check_res("res_o", res_o, exp_res_q[0]);
        check_node("res_num_node_o", res_num_node_o, exp_node_q[0]);
        check_flag("res_src_flag_o", res_src_flag_o, exp_flag_q[0]);
        exp_res_q.delete(0);
        exp_node_q.delete(0);
        exp_flag_q.delete(0);
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    stop_on_error("Timeout while waiting for the DUT to finish all rows");
  end

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    hdr_valid_i    = 1'b0;
    hdr_row_len_i  = '0;
    hdr_num_node_i = '0;
    hdr_src_flag_i = 1'b0;
    nz_valid_i     = 1'b0;
    nz_col_idx_i   = '0;
    nz_val_i       = '0;
    wgt_we_i       = 1'b0;
    wgt_addr_i     = '0;
    wgt_data_i     = '0;
    res_ready_i    = 1'b1;
    bp_en          = 1'b0;
    gap_en         = 1'b0;
    void'($urandom(SEED));

    repeat (10) @(posedge clk);
    check_flag("hdr_ready_o", hdr_ready_o, 1'b0);
    check_flag("nz_ready_o", nz_ready_o, 1'b0);
    check_flag("res_valid_o", res_valid_o, 1'b0);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_flag("hdr_ready_o", hdr_ready_o, 1'b1);

    load_weights(1'b0);
    for (int i = 0; i < N_SINGLE; i++) begin
      send_row(1, 1'b0);
    end
    // Empty rows mixed in with the random ones
    for (int i = 0; i < N_RANDOM; i++) begin
      send_row(int'($urandom_range(1, 16)), 1'b0);
      if (i % 10 == 9) begin
        send_row(0, 1'b0);
      end
    end
    drain();

    bp_en  = 1'b1;
    gap_en = 1'b1;
    for (int i = 0; i < N_BACKPR; i++) begin
      send_row((i % 6 == 5) ? 0 : int'($urandom_range(1, 16)), 1'b0);
    end
    drain();
    bp_en  = 1'b0;
    gap_en = 1'b0;

    // Long rows of extreme values to force lane wrap
    load_weights(1'b1);
    for (int i = 0; i < N_WRAP; i++) begin
      send_row(int'($urandom_range(40, 64)), 1'b1);
    end
    drain();
    repeat (20) @(posedge clk);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: list.f
common/spmm_pkg.sv
common/nz_stream_if.sv
design/csr_row_reader.sv
design/nz_fifo.sv
sparse_pe/weight_bank.sv
sparse_pe/sparse_pe.sv
design/spmm_top.sv
dv/spmm_properties.sv
dv/spmm_tb.sv

// File: Makefile
SRCS := $(shell cat list.f)

.PHONY: all run clean

all: obj_dir/Vspmm_tb

obj_dir/Vspmm_tb: list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module spmm_tb \
		-f list.f -o Vspmm_tb

run: obj_dir/Vspmm_tb
	-./obj_dir/Vspmm_tb > sim.log 2>&1
	@cat sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
